// File: alu.sv
`timescale 1ns/1ps
`include "armcore_params.svh"

// Add, subtract, AND and ORR with NZCV
module alu (
    input  isaPkg::word_t  a,
    input  isaPkg::word_t  b,
    input  isaPkg::aluOp_t aluOp,
    output isaPkg::word_t  result,
    output isaPkg::flags_t flags
);

    localparam int MSB = `ARM_DATA_WIDTH - 1;

    logic                    isSub;    // Subtract as a + ~b + 1
    logic                    isArith;  // C and V only mean something here
    isaPkg::word_t           bOp;      // Operand B after inversion
    logic [`ARM_DATA_WIDTH:0] sum;     // Extra bit holds the carry out

    always_comb begin
        isSub   = (aluOp == isaPkg::ALU_SUB);
        isArith = (aluOp == isaPkg::ALU_ADD) || isSub;
        bOp     = isSub ? ~b : b;
        sum     = {1'b0, a} + {1'b0, bOp} + {{`ARM_DATA_WIDTH{1'b0}}, isSub};

        case (aluOp)
            isaPkg::ALU_AND: result = a & b;
            isaPkg::ALU_ORR: result = a | b;
            default:         result = sum[MSB:0];   // ADD and SUB
        endcase

        flags.n = result[MSB];
        flags.z = (result == '0);
        flags.c = isArith & sum[`ARM_DATA_WIDTH];   // No borrow on subtract
        // Overflow when both inputs agree in sign and the sum does not
        flags.v = isArith & (a[MSB] == bOp[MSB]) & (sum[MSB] != a[MSB]);
    end

endmodule

// File: armCore.sv
`timescale 1ns/1ps

// Three-stage data-processing core
// Decode, execute, then writeback with the register file
module armCore (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrValid,
    input  isaPkg::word_t    instr,
    output logic             wbValid,
    output isaPkg::regAddr_t wbAddr,
    output isaPkg::word_t    wbData
);

    isaPkg::regAddr_t  rdAddrA;   // Decoder reads from the register file
    isaPkg::regAddr_t  rdAddrB;
    isaPkg::word_t     rdDataA;
    isaPkg::word_t     rdDataB;
    pipePkg::exEntry_t exEntry;   // Decode to execute
    pipePkg::wbEntry_t exResult;  // Execute to writeback
    pipePkg::wbEntry_t wbEntry;   // Writeback, back into execute

    instrDecoder u_instrDecoder (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .exEntry    (exEntry)
    );

    executeStage u_executeStage (
        .clk      (clk),
        .rst      (rst),
        .exEntry  (exEntry),
        .wbEntry  (wbEntry),
        .exResult (exResult)
    );

    writebackStage u_writebackStage (
        .clk      (clk),
        .rst      (rst),
        .exResult (exResult),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .wbEntry  (wbEntry),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .wbValid  (wbValid),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

endmodule

// File: armCore_props.sv
`timescale 1ns/1ps

// Timing checks on the external ports of the core
module armCoreProps (
    input logic             clk,
    input logic             rst,
    input logic             instrValid,
    input logic             wbValid,
    input isaPkg::regAddr_t wbAddr,
    input isaPkg::word_t    wbData
);

    // Pipeline comes out of reset empty
    quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> !wbValid)
        else $error("write port active in the first cycle after reset");

    // Two-cycle latency, so the strobe sits three samples back
    writeHasSource: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> $past(instrValid, 3))
        else $error("write port active without an instruction strobe two cycles before");

    knownWrite: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> !$isunknown({wbAddr, wbData}))
        else $error("write address or data unknown while the write port is active");

endmodule

bind armCore armCoreProps u_armCoreProps (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .wbValid    (wbValid),
    .wbAddr     (wbAddr),
    .wbData     (wbData)
);

// File: armcore_params.svh
`ifndef ARMCORE_PARAMS_SVH
`define ARMCORE_PARAMS_SVH

// ----------------------------------------
// Core sizing
// ----------------------------------------

`define ARM_DATA_WIDTH     32   // Word width of the datapath
`define ARM_REG_COUNT      16   // r0 .. r15, r15 is a plain register here
`define ARM_REG_ADDR_WIDTH 4    // Enough bits to name every register

`endif

// File: build.f
+incdir+.
isaPkg.sv
pipePkg.sv
regFile.sv
alu.sv
instrDecoder.sv
executeStage.sv
writebackStage.sv
armCore.sv
armCore_props.sv
tb_armCore.sv

// File: executeStage.sv
`timescale 1ns/1ps

// Processing part of the core
// Forwarding, the ALU, the flags register and the condition check
module executeStage (
    input  logic              clk,
    input  logic              rst,
    input  pipePkg::exEntry_t exEntry,
    input  pipePkg::wbEntry_t wbEntry,    // Previous instruction, for forwarding
    output pipePkg::wbEntry_t exResult
);

    isaPkg::word_t  srcA;        // Operand A after forwarding
    isaPkg::word_t  srcBReg;     // Register operand B after forwarding
    isaPkg::word_t  srcB;        // Operand B into the ALU
    isaPkg::word_t  aluResult;
    isaPkg::flags_t aluFlags;    // Flags from this instruction
    isaPkg::flags_t flagsQ;      // Architectural NZCV
    logic           condPass;

    // ----------------------------------------
    // Forwarding from writeback
    // ----------------------------------------
    // Older results come through the write-first register file
    always_comb begin
        srcA    = (wbEntry.write && (wbEntry.rd == exEntry.rn)) ? wbEntry.result : exEntry.opA;
        srcBReg = (wbEntry.write && (wbEntry.rd == exEntry.rm)) ? wbEntry.result
                                                                : exEntry.opBReg;
        srcB    = exEntry.useImm ? exEntry.imm : srcBReg;   // Immediate wins
    end

    alu u_alu (
        .a      (srcA),
        .b      (srcB),
        .aluOp  (exEntry.aluOp),
        .result (aluResult),
        .flags  (aluFlags)
    );

    // ----------------------------------------
    // Condition check on current flags
    // ----------------------------------------
    always_comb begin
        case (exEntry.cond)
            isaPkg::COND_EQ: condPass = flagsQ.z;
            isaPkg::COND_NE: condPass = ~flagsQ.z;
            isaPkg::COND_GE: condPass = (flagsQ.n == flagsQ.v);
            isaPkg::COND_LT: condPass = (flagsQ.n != flagsQ.v);
            isaPkg::COND_GT: condPass = ~flagsQ.z & (flagsQ.n == flagsQ.v);
            isaPkg::COND_LE: condPass = flagsQ.z | (flagsQ.n != flagsQ.v);
            isaPkg::COND_AL: condPass = 1'b1;
            default:         condPass = 1'b0;   // Unlisted codes never execute
        endcase
    end

    // Flags change only on a valid CMP that passed
    always_ff @(posedge clk) begin
        if (rst) begin
            flagsQ <= '0;
        end else if (exEntry.valid && exEntry.setFlags && condPass) begin
            flagsQ <= aluFlags;
        end
    end

    // Result toward writeback, write bit gated here
    always_comb begin
        exResult.write  = exEntry.valid & exEntry.writeReg & condPass;
        exResult.rd     = exEntry.rd;
        exResult.result = aluResult;
    end

endmodule

// File: instrDecoder.sv
`timescale 1ns/1ps
`include "armcore_params.svh"

// Input side of the core
// Captures strobed instructions, decodes them and builds the execute entry
module instrDecoder (
    input  logic              clk,
    input  logic              rst,
    input  logic              instrValid,   // Single-cycle strobe
    input  isaPkg::word_t     instr,
    input  isaPkg::word_t     rdDataA,      // rn value from the register file
    input  isaPkg::word_t     rdDataB,      // rm value from the register file
    output isaPkg::regAddr_t  rdAddrA,
    output isaPkg::regAddr_t  rdAddrB,
    output pipePkg::exEntry_t exEntry
);

    logic              decValid;   // Decode slot occupied
    isaPkg::word_t     decInstr;   // Instruction held for decode
    pipePkg::exEntry_t nextEntry;  // Decoded entry registered below

    // ----------------------------------------
    // Decode register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) decValid <= 1'b0;
        else     decValid <= instrValid;
        if (instrValid) decInstr <= instr;   // Payload only moves on a strobe
    end

    assign rdAddrA = decInstr[19:16];   // rn
    assign rdAddrB = decInstr[3:0];     // rm

    // ----------------------------------------
    // Opcode table on bits 27:20
    // ----------------------------------------
    always_comb begin
        nextEntry.valid    = decValid;   // Unknown encodings still occupy the slot
        nextEntry.cond     = isaPkg::cond_t'(decInstr[31:28]);
        nextEntry.aluOp    = isaPkg::ALU_ADD;
        nextEntry.useImm   = 1'b0;
        nextEntry.setFlags = 1'b0;
        nextEntry.writeReg = 1'b0;
        nextEntry.rd       = decInstr[15:12];
        nextEntry.rn       = rdAddrA;
        nextEntry.rm       = rdAddrB;
        nextEntry.opA      = rdDataA;
        nextEntry.opBReg   = rdDataB;
        nextEntry.imm      = {{(`ARM_DATA_WIDTH-8){decInstr[7]}}, decInstr[7:0]};

        casez (decInstr[27:20])
            {3'b00?, isaPkg::OPC_ADD, 1'b0}: begin   // ADD with bit 25 picking the immediate
                nextEntry.useImm   = decInstr[25];
                nextEntry.writeReg = 1'b1;
            end
            {3'b00?, isaPkg::OPC_SUB, 1'b0}: begin   // SUB in register or immediate form
                nextEntry.aluOp    = isaPkg::ALU_SUB;
                nextEntry.useImm   = decInstr[25];
                nextEntry.writeReg = 1'b1;
            end
            {3'b00?, isaPkg::OPC_SUB, 1'b1}: begin   // CMP sets flags and writes no rd
                nextEntry.aluOp    = isaPkg::ALU_SUB;
                nextEntry.useImm   = decInstr[25];
                nextEntry.setFlags = 1'b1;
            end
            {3'b000, isaPkg::OPC_AND, 1'b0}: begin   // AND in register form only
                nextEntry.aluOp    = isaPkg::ALU_AND;
                nextEntry.writeReg = 1'b1;
            end
            {3'b000, isaPkg::OPC_ORR, 1'b0}: begin   // ORR in register form only
                nextEntry.aluOp    = isaPkg::ALU_ORR;
                nextEntry.writeReg = 1'b1;
            end
            default: ;                               // No-op
        endcase
    end

    // ----------------------------------------
    // Execute entry register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        exEntry <= nextEntry;
        if (rst) exEntry.valid <= 1'b0;   // Execute slot empty after reset
    end

endmodule

// File: isaPkg.sv
`include "armcore_params.svh"

// Instruction set view of the core
package isaPkg;

    typedef logic [`ARM_DATA_WIDTH-1:0]     word_t;     // One data word
    typedef logic [`ARM_REG_ADDR_WIDTH-1:0] regAddr_t;  // Register number

    // Condition field, bits 31:28
    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,  // Z set
        COND_NE = 4'b0001,  // Z clear
        COND_GE = 4'b1010,  // N equals V
        COND_LT = 4'b1011,  // N differs from V
        COND_GT = 4'b1100,  // Z clear and N equals V
        COND_LE = 4'b1101,  // Z set or N differs from V
        COND_AL = 4'b1110   // Always
    } cond_t;

    // ALU operation select
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_ORR = 2'b11
    } aluOp_t;

    // Status flags, N in the top bit
    typedef struct packed {
        logic n;    // Negative
        logic z;    // Zero
        logic c;    // Carry out, no borrow on subtract
        logic v;    // Signed overflow
    } flags_t;

    // Data-processing opcodes in bits 24:21
    localparam logic [3:0] OPC_ADD = 4'b0100;
    localparam logic [3:0] OPC_SUB = 4'b0010;   // CMP is SUB with S set
    localparam logic [3:0] OPC_AND = 4'b0000;
    localparam logic [3:0] OPC_ORR = 4'b1100;

endpackage

// File: pipePkg.sv
// Pipeline view of the core, the entries handed between stages
package pipePkg;

    // ----------------------------------------
    // Decode to execute
    // ----------------------------------------
    typedef struct packed {
        logic             valid;     // Slot holds an instruction
        isaPkg::cond_t    cond;      // Condition field
        isaPkg::aluOp_t   aluOp;     // ALU operation
        logic             useImm;    // Operand B from the immediate
        logic             setFlags;  // CMP, updates NZCV
        logic             writeReg;  // Writes rd when its condition passes
        isaPkg::regAddr_t rd;        // Destination
        isaPkg::regAddr_t rn;        // Source A, kept for forwarding
        isaPkg::regAddr_t rm;        // Source B, kept for forwarding
        isaPkg::word_t    opA;       // Value read from rn
        isaPkg::word_t    opBReg;    // Value read from rm
        isaPkg::word_t    imm;       // Sign-extended bits 7:0
    } exEntry_t;

    // ----------------------------------------
    // Execute to writeback
    // ----------------------------------------
    typedef struct packed {
        logic             write;     // Commit to the register file
        isaPkg::regAddr_t rd;        // Destination
        isaPkg::word_t    result;    // ALU result
    } wbEntry_t;

endpackage

// File: regFile.sv
`timescale 1ns/1ps
`include "armcore_params.svh"

// Sixteen-entry register file, two read ports and one write port
module regFile (
    input  logic             clk,
    input  logic             rst,
    input  logic             wrEn,
    input  isaPkg::regAddr_t wrAddr,
    input  isaPkg::word_t    wrData,
    input  isaPkg::regAddr_t rdAddrA,
    input  isaPkg::regAddr_t rdAddrB,
    output isaPkg::word_t    rdDataA,
    output isaPkg::word_t    rdDataB
);

    isaPkg::word_t regs [`ARM_REG_COUNT];   // Architectural registers

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};         // All registers read zero after reset
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-first bypass
    // A read of the register being written returns the new value
    assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the core and its testbench with Verilator, then runs the simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_armCore -o simArmCore

output="$(./obj_dir/simArmCore 2>&1)" || true
echo "$output"

echo "$output" | grep -qxF ">>> PASS"

// File: tb_armCore.sv
`timescale 1ns/1ps
`include "armcore_params.svh"

module tb_armCore;

    localparam logic [31:0] SEED        = 32'he414_be38;
    localparam int          MSB         = `ARM_DATA_WIDTH - 1;
    localparam int          N_RESET_OPS = `ARM_REG_COUNT;   // One ADD per register
    localparam int          N_CHAIN     = 64;
    localparam int          N_IMM       = 40;
    localparam int          N_COND      = 6;                // Rounds of a CMP and eight conditional ops
    localparam int          N_NOOP      = 48;
    localparam int          ISSUE_TOTAL = N_RESET_OPS + N_CHAIN + N_IMM + N_COND * 9 + N_NOOP;
    localparam int          CYCLE_LIMIT = 2 * ISSUE_TOTAL + 16 + 20;
    localparam logic [3:0]  AL          = 4'b1110;

    localparam logic [3:0] CHAIN_OPS [4] = '{isaPkg::OPC_ADD, isaPkg::OPC_SUB,
                                             isaPkg::OPC_AND, isaPkg::OPC_ORR};
    // EQ NE GE LT GT LE AL
    localparam logic [3:0] CONDS [7] = '{4'b0000, 4'b0001, 4'b1010, 4'b1011,
                                         4'b1100, 4'b1101, 4'b1110};

    typedef struct packed {
        isaPkg::regAddr_t addr;
        isaPkg::word_t    data;
    } expWrite_t;

    logic             clk;
    logic             rst;
    logic             instrValid;
    isaPkg::word_t    instr;
    logic             wbValid;
    isaPkg::regAddr_t wbAddr;
    isaPkg::word_t    wbData;

    logic [31:0]      lfsr;
    isaPkg::word_t    modelRegs [`ARM_REG_COUNT];   // Reference register file
    isaPkg::flags_t   modelFlags;
    expWrite_t        expQ [$];                     // Writes still owed by the DUT
    isaPkg::regAddr_t lastRd;                       // Recent destinations for hazards
    isaPkg::regAddr_t prevRd;
    string            testName;
    int               cycles = 0;
    int               checks = 0;
    int               errors = 0;
    int               testChecks = 0;
    int               testErrors = 0;
    int               testsRun = 0;

    armCore u_armCore (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData)
    );

    always #50 clk = ~clk;   // 100 ns period

    // ----------------------------------------
    // Random source and instruction builders
    // ----------------------------------------
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            bits = {bits[30:0], lfsr[0]};   // One step per bit
        end
        return bits;
    endfunction

    // Often one of the last two destinations to hit forwarding
    function automatic isaPkg::regAddr_t pickReg();
        logic [1:0] sel;
        sel = 2'(takeBits(2));
        if (sel == 2'd0) return lastRd;
        if (sel == 2'd1) return prevRd;
        return 4'(takeBits(4));
    endfunction

    function automatic isaPkg::word_t dpInstr(input logic [3:0] cond, input logic immForm,
                                              input logic [3:0] opc, input logic s,
                                              input isaPkg::regAddr_t rn,
                                              input isaPkg::regAddr_t rd,
                                              input logic [11:0] op2);
        return {cond, 2'b00, immForm, opc, s, rn, rd, op2};
    endfunction

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic condHolds(input logic [3:0] cond, input isaPkg::flags_t f);
        case (cond)
            4'b0000: return f.z;
            4'b0001: return !f.z;
            4'b1010: return f.n == f.v;
            4'b1011: return f.n != f.v;
            4'b1100: return !f.z && (f.n == f.v);
            4'b1101: return f.z || (f.n != f.v);
            4'b1110: return 1'b1;
            default: return 1'b0;   // Unlisted codes never run
        endcase
    endfunction

    task automatic modelExecute(input isaPkg::word_t ins);
        isaPkg::word_t a;
        isaPkg::word_t b;
        isaPkg::word_t r;
        expWrite_t     w;
        logic          writes;
        a      = modelRegs[ins[19:16]];
        b      = ins[25] ? isaPkg::word_t'($signed(ins[7:0])) : modelRegs[ins[3:0]];
        r      = '0;
        writes = 1'b0;
        if (ins[27:26] == 2'b00 && condHolds(ins[31:28], modelFlags)) begin
            case ({ins[24:21], ins[20]})
                {isaPkg::OPC_ADD, 1'b0}: begin
                    r      = a + b;
                    writes = 1'b1;
                end
                {isaPkg::OPC_SUB, 1'b0}: begin
                    r      = a - b;
                    writes = 1'b1;
                end
                {isaPkg::OPC_SUB, 1'b1}: begin   // CMP updates flags only
                    r            = a - b;
                    modelFlags.n = r[MSB];
                    modelFlags.z = (r == '0);
                    modelFlags.c = (a >= b);     // No borrow
                    modelFlags.v = (a[MSB] != b[MSB]) && (r[MSB] != a[MSB]);
                end
                {isaPkg::OPC_AND, 1'b0}: begin
                    r      = a & b;
                    writes = !ins[25];           // Register form only
                end
                {isaPkg::OPC_ORR, 1'b0}: begin
                    r      = a | b;
                    writes = !ins[25];
                end
                default: ;
            endcase
        end
        if (writes) begin
            modelRegs[ins[15:12]] = r;
            w.addr = ins[15:12];
            w.data = r;
            expQ.push_back(w);
            prevRd = lastRd;
            lastRd = ins[15:12];
        end
    endtask

    // ----------------------------------------
    // Driving and checking
    // ----------------------------------------
    // Called and returns on a falling edge
    task automatic sendInstr(input isaPkg::word_t ins, input logic allowGap);
        instrValid = 1'b1;
        instr      = ins;
        modelExecute(ins);
        @(negedge clk);
        instrValid = 1'b0;
        if (allowGap && takeBits(1) != 0) begin
            repeat (takeBits(2)) @(negedge clk);   // Idle strobe cycles
        end
    endtask

    task automatic checkWrite();
        expWrite_t exp;
        checks++;
        testChecks++;
        assert (expQ.size() != 0) else begin
            $display("Unexpected write of %08h to r%0d in test %s", wbData, wbAddr, testName);
            errors++;
            testErrors++;
        end
        if (expQ.size() != 0) begin
            exp = expQ.pop_front();
            assert (wbAddr == exp.addr && wbData == exp.data) else begin
                $display("Fail %s expected r%0d=%08h actual r%0d=%08h",
                         testName, exp.addr, exp.data, wbAddr, wbData);
                errors++;
                testErrors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && wbValid) checkWrite();   // Outputs settled mid-cycle
    end

    task automatic finishTest();
        while (expQ.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);           // Longer than the pipeline so strays show up
        testsRun++;
        if (testErrors == 0) begin
            $display("Test %s: ok, %0d writes checked", testName, testChecks);
        end else begin
            $display("Test %s: %0d errors in %0d writes", testName, testErrors, testChecks);
        end
        testErrors = 0;
        testChecks = 0;
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d expected writes never seen",
                     cycles, expQ.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        isaPkg::word_t    ins;
        isaPkg::regAddr_t rn;
        isaPkg::regAddr_t rm;
        isaPkg::regAddr_t rd;
        logic [3:0]       opc;
        logic [3:0]       cond;
        logic [7:0]       imm;
        clk        = 1'b0;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        lfsr       = SEED;
        modelFlags = '0;
        lastRd     = '0;
        prevRd     = '0;
        for (int r = 0; r < `ARM_REG_COUNT; r++) modelRegs[r] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Idle core first and then rN = rN + imm on every zeroed register
        testName = "reset";
        repeat (4) @(negedge clk);
        for (int r = 0; r < N_RESET_OPS; r++) begin
            imm = 8'(takeBits(8));
            sendInstr(dpInstr(AL, 1'b1, isaPkg::OPC_ADD, 1'b0, 4'(r), 4'(r), {4'h0, imm}), 1'b0);
        end
        finishTest();

        testName = "chains";   // Back to back without gaps
        for (int k = 0; k < N_CHAIN; k++) begin
            opc = CHAIN_OPS[2'(takeBits(2))];
            rn  = pickReg();
            rm  = pickReg();
            rd  = 4'(takeBits(4));
            sendInstr(dpInstr(AL, 1'b0, opc, 1'b0, rn, rd, {8'h00, rm}), 1'b0);
        end
        finishTest();

        testName = "immediates";
        for (int k = 0; k < N_IMM; k++) begin
            opc = (takeBits(1) != 0) ? isaPkg::OPC_SUB : isaPkg::OPC_ADD;
            rn  = pickReg();
            rd  = 4'(takeBits(4));
            imm = 8'(takeBits(8));   // Bit 7 set about half the time
            sendInstr(dpInstr(AL, 1'b1, opc, 1'b0, rn, rd, {4'h0, imm}), 1'b1);
        end
        finishTest();

        testName = "conditions";
        for (int k = 0; k < N_COND; k++) begin
            rn = pickReg();
            rm = (takeBits(1) != 0) ? rn : 4'(takeBits(4));   // Same register gives Z
            sendInstr(dpInstr(AL, 1'b0, isaPkg::OPC_SUB, 1'b1, rn, 4'h0, {8'h00, rm}), 1'b0);
            for (int c = 0; c < 8; c++) begin
                cond = (c < 7) ? CONDS[c] : 4'h2 + 4'(takeBits(3));   // Last one unlisted
                rn   = pickReg();
                rd   = 4'(takeBits(4));
                imm  = 8'(takeBits(8));
                sendInstr(dpInstr(cond, 1'b1, isaPkg::OPC_ADD, 1'b0, rn, rd, {4'h0, imm}),
                          1'b0);
            end
        end
        finishTest();

        testName = "noops";
        for (int k = 0; k < N_NOOP; k++) begin
            case (2'(takeBits(2)))
                2'd0: begin   // CMP
                    rn = pickReg();
                    rm = 4'(takeBits(4));
                    sendInstr(dpInstr(AL, 1'b0, isaPkg::OPC_SUB, 1'b1, rn, 4'h0, {8'h00, rm}),
                              1'b1);
                end
                2'd1: begin   // Outside the data-processing space
                    ins        = takeBits(32);
                    ins[27:26] = 2'b11;
                    sendInstr(ins, 1'b1);
                end
                default: begin
                    opc = CHAIN_OPS[2'(takeBits(2))];
                    rn  = pickReg();
                    rm  = pickReg();
                    rd  = 4'(takeBits(4));
                    sendInstr(dpInstr(AL, 1'b0, opc, 1'b0, rn, rd, {8'h00, rm}), 1'b1);
                end
            endcase
        end
        finishTest();

        $display("Tests %0d, writes checked %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: writebackStage.sv
`timescale 1ns/1ps

// Output side of the core
// Writeback register, register file and the external write port
module writebackStage (
    input  logic              clk,
    input  logic              rst,
    input  pipePkg::wbEntry_t exResult,
    input  isaPkg::regAddr_t  rdAddrA,
    input  isaPkg::regAddr_t  rdAddrB,
    output pipePkg::wbEntry_t wbEntry,    // Also fed back for forwarding
    output isaPkg::word_t     rdDataA,
    output isaPkg::word_t     rdDataB,
    output logic              wbValid,
    output isaPkg::regAddr_t  wbAddr,
    output isaPkg::word_t     wbData
);

    always_ff @(posedge clk) begin
        wbEntry <= exResult;
        if (rst) wbEntry.write <= 1'b0;   // No commit straight out of reset
    end

    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .wrEn    (wbEntry.write),   // Commit at the edge ending writeback
        .wrAddr  (wbEntry.rd),
        .wrData  (wbEntry.result),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    // Same commit, shown to the outside for one cycle
    assign wbValid = wbEntry.write;
    assign wbAddr  = wbEntry.rd;
    assign wbData  = wbEntry.result;

endmodule
